// ==== sim/csr_vectors.txt ====
# kind f3_or_cause addr operand_or_tval pc_or_epc exp_rdata_or_priv exp_illegal exp_redirect
# All hex. Reads of B00, C00, C01 only check that the count grows
CSR 2 300 0 100 1800 0 0
CSR 2 301 0 104 8000000000101100 0 0
CSR 2 F11 0 108 0 0 0
CSR 2 F12 0 10c 25 0 0
CSR 2 F13 0 110 102 0 0
CSR 2 F14 0 114 0 0 0
CSR 1 340 a5a5f0f0 118 0 0 0
CSR 2 340 f 11c a5a5f0f0 0 0
CSR 3 340 a0a0000f 120 a5a5f0ff 0 0
CSR 5 340 15 124 0505f0f0 0 0
CSR 6 340 a 128 15 0 0
CSR 7 340 3 12c 1f 0 0
CSR 2 340 0 130 1c 0 0
CSR 1 341 1235 134 0 0 0
CSR 2 341 0 138 1234 0 0
CSR 1 305 80000007 13c 0 0 0
CSR 2 305 0 140 80000005 0 0
CSR 1 300 ffffffffffffffff 144 1800 0 0
CSR 2 300 0 148 1888 0 0
CSR 1 C00 5 14c 0 1 80000004
CSR 2 342 0 150 2 0 0
CSR 2 341 0 154 14c 0 0
CSR 1 7C0 1 158 0 1 80000004
CSR 2 341 0 15c 158 0 0
CSR 6 C00 0 160 0 0 0
CSR 6 300 8 164 1800 0 0
TRAP b 0 dead 2000 3 0 80000004
CSR 2 342 0 168 b 0 0
CSR 2 341 0 16c 2000 0 0
CSR 2 343 0 170 dead 0 0
CSR 2 300 0 174 1880 0 0
MRET 0 0 0 0 3 0 2000
CSR 2 300 0 178 88 0 0
MRET 0 0 0 0 0 0 2000
CSR 2 B02 0 17c 0 0 0
RETIRE 0 0 5 0 0 0 0
CSR 2 B02 0 180 5 0 0
RETIRE 0 0 3 0 0 0 0
CSR 2 C02 0 184 8 0 0
CSR 2 B00 0 188 0 0 0
CSR 2 B00 0 18c 0 0 0

// ==== tb.f ====
+incdir+include
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/csr_file.sv
hdl/trap_ctrl.sv
hdl/csr_unit.sv
sim/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/csr_pkg.sv
      - hdl/trap_pkg.sv
      - hdl/csr_file.sv
      - hdl/trap_ctrl.sv
      - hdl/csr_unit.sv
  - target: simulation
    files:
      - sim/csr_unit_tb.sv

// ==== sim/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    localparam int XLEN    = 64;
    localparam int TIMEOUT = 64;   // Cycles allowed per wait

    logic              clk;
    logic              rst;
    logic              inst_retired;
    logic              req_valid;
    logic              req_ready;
    logic [XLEN-1:0]   req_pc;
    logic [11:0]       req_addr;
    csr_funct3_e       req_funct3;
    logic [4:0]        req_rd;
    logic [4:0]        req_rs1_uimm;
    logic [XLEN-1:0]   req_rs1_data;
    logic              resp_valid;
    logic              resp_ready;
    logic [XLEN-1:0]   resp_rdata;
    logic              resp_illegal;
    logic              trap_valid;
    trap_cause_e       trap_cause;
    logic [XLEN-1:0]   trap_epc;
    logic [XLEN-1:0]   trap_tval;
    logic              mret_valid;
    logic              redirect_valid;
    logic [XLEN-1:0]   redirect_pc;
    priv_level_e       privilege_mode;

    integer          seed;
    integer          errors;
    integer          accepts;
    integer          responses;
    integer          csr_ops;
    logic            stalled;
    logic [XLEN-1:0] held_rdata;
    logic [XLEN-1:0] last_cycle;

    csr_unit #(
        .XLEN    (XLEN),
        .HART_ID (0)
    ) csr_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random stalls on the response side
    always @(posedge clk) begin
        resp_ready <= ($random(seed) & 3) != 0;
    end

    // Handshake bookkeeping, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled && (!resp_valid || resp_rdata != held_rdata)) begin
                $display("FAILED stall hold expected %h actual %h", held_rdata, resp_rdata);
                errors++;
            end
            stalled = resp_valid && !resp_ready;
            if (stalled) begin
                held_rdata = resp_rdata;
                if (req_ready) begin
                    $display("req_ready is high while a response is stalled");
                    errors++;
                end
            end
            if (req_valid && req_ready) accepts++;
            if (resp_valid && resp_ready) responses++;
        end
    end

    function automatic logic is_cycle_addr(input logic [11:0] addr);
        return addr == 12'hB00 || addr == 12'hC00 || addr == 12'hC01;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Called just after the event edge; the redirect must show one cycle later
    task automatic check_redirect(input string name, input logic [XLEN-1:0] exp_pc);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!redirect_valid && n < TIMEOUT);
        if (!redirect_valid) begin
            $display("%s: timed out waiting for redirect_valid", name);
            errors++;
        end else begin
            check_value({name, " redirect latency"}, 1, n);
            check_value({name, " redirect_pc"}, exp_pc, redirect_pc);
        end
    endtask

    task automatic csr_op(input string name, input logic [3:0] f3, input logic [11:0] addr,
                          input logic [XLEN-1:0] operand, input logic [XLEN-1:0] pc,
                          input logic [XLEN-1:0] exp_data, input logic exp_ill,
                          input logic [XLEN-1:0] exp_redir);
        int n;
        csr_ops++;
        @(posedge clk);
        req_valid <= 1'b1;
        req_funct3 <= csr_funct3_e'(f3[2:0]);
        req_addr <= addr;
        req_pc <= pc;
        req_rd <= 5'd1;
        req_rs1_data <= operand;
        req_rs1_uimm <= f3[2] ? operand[4:0] : ((operand != 0) ? 5'd1 : 5'd0);
        n = 0;
        @(negedge clk);
        while (!req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("%s: timed out waiting for req_ready", name);
            errors++;
            @(posedge clk);
            req_valid <= 1'b0;
            return;
        end
        @(posedge clk);   // Accept edge
        req_valid <= 1'b0;
        if (exp_ill) begin
            check_redirect(name, exp_redir);
        end else begin
            @(negedge clk);
            check_value({name, " no redirect"}, 0, redirect_valid);
        end
        n = 0;
        while (!(resp_valid && resp_ready) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!(resp_valid && resp_ready)) begin
            $display("%s: timed out waiting for resp_valid", name);
            errors++;
            return;
        end
        check_value({name, " illegal"}, exp_ill, resp_illegal);
        if (!exp_ill && is_cycle_addr(addr)) begin
            if (resp_rdata <= last_cycle) begin
                $display("FAILED %s cycle count expected above %h actual %h",
                         name, last_cycle, resp_rdata);
                errors++;
            end
            last_cycle = resp_rdata;
        end else begin
            check_value({name, " rdata"}, exp_data, resp_rdata);
        end
    endtask

    task automatic pipeline_event(input string name, input logic is_trap, input logic [3:0] cause,
                                  input logic [XLEN-1:0] tval, input logic [XLEN-1:0] epc,
                                  input logic [XLEN-1:0] exp_priv,
                                  input logic [XLEN-1:0] exp_redir);
        @(posedge clk);
        trap_valid <= is_trap;
        mret_valid <= !is_trap;
        trap_cause <= trap_cause_e'(cause);
        trap_epc <= epc;
        trap_tval <= tval;
        @(posedge clk);   // Event edge
        trap_valid <= 1'b0;
        mret_valid <= 1'b0;
        check_redirect(name, exp_redir);
        check_value({name, " privilege"}, exp_priv, privilege_mode);
    endtask

    initial begin
        int              fd;
        int              n;
        int              line_no;
        string           line;
        string           name;
        logic [47:0]     kind;
        logic [3:0]      f3;
        logic [11:0]     addr;
        logic [XLEN-1:0] operand;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] exp_data;
        logic [XLEN-1:0] exp_ill;
        logic [XLEN-1:0] exp_redir;

        seed = 32'hfff8_6c5b;
        errors = 0;
        accepts = 0;
        responses = 0;
        csr_ops = 0;
        stalled = 1'b0;
        held_rdata = '0;
        last_cycle = '0;
        rst = 1'b1;
        inst_retired = 1'b0;
        req_valid = 1'b0;
        req_pc = '0;
        req_addr = '0;
        req_funct3 = CSRRS;
        req_rd = '0;
        req_rs1_uimm = '0;
        req_rs1_data = '0;
        resp_ready = 1'b1;
        trap_valid = 1'b0;
        trap_cause = ILLEGAL_INSTR;
        trap_epc = '0;
        trap_tval = '0;
        mret_valid = 1'b0;
        line_no = 0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("sim/csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/csr_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (n == 0 || line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                            kind, f3, addr, operand, pc, exp_data, exp_ill, exp_redir);
                name = $sformatf("line %0d", line_no);
                if (n != 8) begin
                    $display("Malformed vector on line %0d", line_no);
                    errors++;
                end else if (kind == "CSR") begin
                    csr_op(name, f3, addr, operand, pc, exp_data, exp_ill[0], exp_redir);
                end else if (kind == "TRAP" || kind == "MRET") begin
                    pipeline_event(name, kind == "TRAP", f3, operand, pc, exp_data, exp_redir);
                end else if (kind == "RETIRE") begin
                    repeat (operand[7:0]) begin
                        @(posedge clk);
                        inst_retired <= 1'b1;
                        @(posedge clk);
                        inst_retired <= 1'b0;
                    end
                end else begin
                    $display("Unknown vector kind on line %0d", line_no);
                    errors++;
                end
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        check_value("accepted requests", csr_ops, accepts);
        check_value("responses", csr_ops, responses);
        $display("%0d errors over %0d requests", errors, csr_ops);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter int XLEN    = 64,
    parameter int HART_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_retired,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [XLEN-1:0]       req_pc,
    input  logic [11:0]           req_addr,
    input  csr_pkg::csr_funct3_e  req_funct3,
    input  logic [4:0]            req_rd,
    input  logic [4:0]            req_rs1_uimm,
    input  logic [XLEN-1:0]       req_rs1_data,

    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [XLEN-1:0]       resp_rdata,
    output logic                  resp_illegal,

    input  logic                  trap_valid,
    input  trap_pkg::trap_cause_e trap_cause,
    input  logic [XLEN-1:0]       trap_epc,
    input  logic [XLEN-1:0]       trap_tval,

    input  logic                  mret_valid,

    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    output csr_pkg::priv_level_e  privilege_mode
);
    import csr_pkg::*;
    import trap_pkg::*;

    // CSR file to trap controller
    logic            csr_illegal_fire;
    logic [XLEN-1:0] csr_illegal_pc;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    // Trap controller back to the CSR file
    logic            trap_do_update;
    trap_cause_e     trap_mcause;
    logic [XLEN-1:0] trap_mepc;
    logic [XLEN-1:0] trap_mtval;
    logic            xret_do_update;
    logic [XLEN-1:0] xret_new_mstatus;
    priv_level_e     xret_new_priv;

    csr_file #(
        .XLEN    (XLEN),
        .HART_ID (HART_ID)
    ) csr_file_i (.*);

    trap_ctrl #(
        .XLEN (XLEN)
    ) trap_ctrl_i (.*);

endmodule

// ==== hdl/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  csr_illegal_fire,
    input  logic [XLEN-1:0]       csr_illegal_pc,

    input  logic                  trap_valid,
    input  trap_pkg::trap_cause_e trap_cause,
    input  logic [XLEN-1:0]       trap_epc,
    input  logic [XLEN-1:0]       trap_tval,

    input  logic                  mret_valid,

    input  logic [XLEN-1:0]       mstatus,
    input  logic [XLEN-1:0]       mtvec,
    input  logic [XLEN-1:0]       mepc,

    output logic                  trap_do_update,
    output trap_pkg::trap_cause_e trap_mcause,
    output logic [XLEN-1:0]       trap_mepc,
    output logic [XLEN-1:0]       trap_mtval,

    output logic                  xret_do_update,
    output logic [XLEN-1:0]       xret_new_mstatus,
    output csr_pkg::priv_level_e  xret_new_priv,

    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc
);
    import csr_pkg::*;
    import trap_pkg::*;

    typedef enum logic [1:0] {
        EV_NONE,
        EV_ILLEGAL,
        EV_TRAP,
        EV_MRET
    } event_e;

    event_e ev;

    // Fixed priority, losers are dropped
    always_comb begin
        if (csr_illegal_fire) begin
            ev = EV_ILLEGAL;
        end else if (trap_valid) begin
            ev = EV_TRAP;
        end else if (mret_valid) begin
            ev = EV_MRET;
        end else begin
            ev = EV_NONE;
        end
    end

    assign trap_do_update = (ev == EV_ILLEGAL) || (ev == EV_TRAP);
    assign xret_do_update = (ev == EV_MRET);

    always_comb begin
        trap_mcause = trap_cause;
        trap_mepc = trap_epc;
        trap_mtval = trap_tval;
        if (ev == EV_ILLEGAL) begin
            trap_mcause = ILLEGAL_INSTR;
            trap_mepc = csr_illegal_pc;
            trap_mtval = '0;
        end
    end

    // mret unstacks MIE and drops MPP to the lowest mode
    always_comb begin
        xret_new_mstatus = mstatus;
        xret_new_mstatus[MSTATUS_MIE] = mstatus[MSTATUS_MPIE];
        xret_new_mstatus[MSTATUS_MPIE] = 1'b1;
        xret_new_mstatus[MSTATUS_MPP_LO +: 2] = USER;
    end

    assign xret_new_priv = priv_level_e'(mstatus[MSTATUS_MPP_LO +: 2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= trap_do_update || xret_do_update;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_do_update) begin
            redirect_pc <= {mtvec[XLEN-1:2], 2'b00};   // Direct mode only
        end else if (xret_do_update) begin
            redirect_pc <= mepc;
        end
    end

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ps
`include "core_ids.svh"

module csr_file #(
    parameter int XLEN    = 64,
    parameter int HART_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_retired,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic [XLEN-1:0]      req_pc,
    input  logic [11:0]          req_addr,
    input  csr_pkg::csr_funct3_e req_funct3,
    input  logic [4:0]           req_rd,
    input  logic [4:0]           req_rs1_uimm,
    input  logic [XLEN-1:0]      req_rs1_data,

    output logic                 resp_valid,
    input  logic                 resp_ready,
    output logic [XLEN-1:0]      resp_rdata,
    output logic                 resp_illegal,

    output logic                 csr_illegal_fire,
    output logic [XLEN-1:0]      csr_illegal_pc,

    input  logic                 trap_do_update,
    input  trap_pkg::trap_cause_e trap_mcause,
    input  logic [XLEN-1:0]      trap_mepc,
    input  logic [XLEN-1:0]      trap_mtval,

    input  logic                 xret_do_update,
    input  logic [XLEN-1:0]      xret_new_mstatus,
    input  csr_pkg::priv_level_e xret_new_priv,

    output csr_pkg::priv_level_e privilege_mode,
    output logic [XLEN-1:0]      mstatus,
    output logic [XLEN-1:0]      mtvec,
    output logic [XLEN-1:0]      mepc
);
    import csr_pkg::*;

    localparam logic [1:0] MXL = (XLEN == 64) ? 2'd2 : 2'd1;
    localparam logic [XLEN-1:0] MISA_VALUE = {MXL, {(XLEN-28){1'b0}}, 26'h0101100}; // I, M, U
    localparam logic [XLEN-1:0] MSTATUS_RESET = XLEN'(MACHINE) << MSTATUS_MPP_LO;

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] minstret;

    logic            accept;
    logic            is_write;
    logic            is_read;
    logic            bad_addr;
    logic            illegal;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] wr_src;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] trap_mstatus;

    // Only MIE and MPIE are writable, MPP stays MACHINE
    function automatic logic [XLEN-1:0] mstatus_wr(input logic [XLEN-1:0] d);
        logic [XLEN-1:0] m;
        m = '0;
        m[MSTATUS_MIE] = d[MSTATUS_MIE];
        m[MSTATUS_MPIE] = d[MSTATUS_MPIE];
        m[MSTATUS_MPP_LO +: 2] = MACHINE;
        return m;
    endfunction

    assign req_ready = !resp_valid || resp_ready;
    assign accept = req_valid && req_ready;

    // Set/clear with x0 or zero uimm does not write
    assign is_write = (req_funct3 == CSRRW) || (req_funct3 == CSRRWI) || (req_rs1_uimm != 5'd0);
    assign is_read = !((req_funct3 == CSRRW) || (req_funct3 == CSRRWI)) || (req_rd != 5'd0);
    assign illegal = bad_addr || (is_write && req_addr[11:10] == 2'b11);

    assign csr_illegal_fire = accept && illegal;
    assign csr_illegal_pc = req_pc;

    always_comb begin
        bad_addr = 1'b0;
        case (req_addr)
            CSR_MSTATUS:   csr_rdata = mstatus;
            CSR_MISA:      csr_rdata = MISA_VALUE;
            CSR_MTVEC:     csr_rdata = mtvec;
            CSR_MSCRATCH:  csr_rdata = mscratch;
            CSR_MEPC:      csr_rdata = mepc;
            CSR_MCAUSE:    csr_rdata = mcause;
            CSR_MTVAL:     csr_rdata = mtval;
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME: csr_rdata = mcycle;   // No separate timer
            CSR_MINSTRET, CSR_INSTRET:       csr_rdata = minstret;
            CSR_MVENDORID: csr_rdata = XLEN'(`CORE_MVENDORID);
            CSR_MARCHID:   csr_rdata = XLEN'(`CORE_MARCHID);
            CSR_MIMPID:    csr_rdata = XLEN'(`CORE_MIMPID);
            CSR_MHARTID:   csr_rdata = XLEN'(HART_ID);
            default: begin
                csr_rdata = '0;
                bad_addr = 1'b1;
            end
        endcase
    end

    assign wr_src = req_funct3[2] ? XLEN'(req_rs1_uimm) : req_rs1_data;

    always_comb begin
        case (req_funct3)
            CSRRS, CSRRSI: wr_data = csr_rdata | wr_src;
            CSRRC, CSRRCI: wr_data = csr_rdata & ~wr_src;
            default:       wr_data = wr_src;
        endcase
    end

    // Trap entry stacks MIE and the current privilege
    always_comb begin
        trap_mstatus = mstatus;
        trap_mstatus[MSTATUS_MPP_LO +: 2] = privilege_mode;
        trap_mstatus[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
        trap_mstatus[MSTATUS_MIE] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege_mode <= MACHINE;
            mstatus <= MSTATUS_RESET;
            mtvec <= '0;
            mepc <= '0;
            mscratch <= '0;
            mcause <= '0;
            mtval <= '0;
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            if (inst_retired) begin
                minstret <= minstret + 1'b1;
            end

            if (accept && is_write && !illegal) begin
                case (req_addr)
                    CSR_MSTATUS:  mstatus <= mstatus_wr(wr_data);
                    CSR_MTVEC:    mtvec <= {wr_data[XLEN-1:2], 1'b0, wr_data[0]};
                    CSR_MSCRATCH: mscratch <= wr_data;
                    CSR_MEPC:     mepc <= {wr_data[XLEN-1:1], 1'b0};
                    CSR_MCAUSE:   mcause <= wr_data;
                    CSR_MTVAL:    mtval <= wr_data;
                    CSR_MCYCLE:   mcycle <= wr_data;
                    CSR_MINSTRET: minstret <= wr_data;
                    default: ;    // misa ignores writes
                endcase
            end

            if (xret_do_update) begin
                mstatus <= xret_new_mstatus;
                privilege_mode <= xret_new_priv;
            end

            // Trap wins over a CSR write in the same cycle
            if (trap_do_update) begin
                mcause <= XLEN'(trap_mcause);
                mepc <= trap_mepc;
                mtval <= trap_mtval;
                mstatus <= trap_mstatus;
                privilege_mode <= MACHINE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_rdata <= (illegal || !is_read) ? '0 : csr_rdata;
            resp_illegal <= illegal;
        end
    end

endmodule

// ==== hdl/trap_pkg.sv ====
package trap_pkg;

    // Synchronous exception codes, mcause with interrupt bit clear
    typedef enum logic [3:0] {
        INSTR_MISALIGNED   = 4'd0,
        INSTR_ACCESS_FAULT = 4'd1,
        ILLEGAL_INSTR      = 4'd2,
        BREAKPOINT         = 4'd3,
        LOAD_MISALIGNED    = 4'd4,
        LOAD_ACCESS_FAULT  = 4'd5,
        STORE_MISALIGNED   = 4'd6,
        STORE_ACCESS_FAULT = 4'd7,
        ECALL_U            = 4'd8,
        ECALL_S            = 4'd9,
        ECALL_M            = 4'd11
    } trap_cause_e;

endpackage

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    typedef enum logic [1:0] {
        USER       = 2'b00,
        RESERVED1  = 2'b01,
        SUPERVISOR = 2'b10,
        MACHINE    = 2'b11
    } priv_level_e;

    // Zicsr funct3 field
    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_funct3_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_CYCLE     = 12'hC00,   // User aliases, read only
        CSR_TIME      = 12'hC01,
        CSR_INSTRET   = 12'hC02,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // mstatus fields
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;   // MPP is two bits wide

endpackage

// ==== include/core_ids.svh ====
`ifndef CORE_IDS_SVH
`define CORE_IDS_SVH

// Non-commercial core, no JEDEC vendor code
`define CORE_MVENDORID 32'h0000_0000
`define CORE_MARCHID   32'h0000_0025
`define CORE_MIMPID    32'h0000_0102

`endif
